// File: hdl/bridge_config.svh
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

//////////////////////////////////////////////////////////////////////
// Clock crossing
//////////////////////////////////////////////////////////////////////

// FIFO depth is 2**BRIDGE_FIFO_AW entries
`define BRIDGE_FIFO_AW 2
`define BRIDGE_SYNC_STAGES 2

`endif

// File: hdl/bridge_pkg.sv
`include "bridge_config.svh"

package bridge_pkg;

    // Request entry, address phase merged with its data phase
    typedef struct packed {
        logic [`BRIDGE_ADDR_W-1:0]   addr;
        logic                        write;
        logic [`BRIDGE_DATA_W-1:0]   wdata;
        logic [`BRIDGE_DATA_W/8-1:0] strb;
    } apb_req_t;

    // Response entry back to the AHB side
    typedef struct packed {
        logic [`BRIDGE_DATA_W-1:0] rdata;
        logic                      slverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    // One-hot APB sequencer states
    typedef enum logic [2:0] {
        APB_IDLE   = 3'b001,
        APB_SETUP  = 3'b010,
        APB_ACCESS = 3'b100
    } apb_state_e;

endpackage : bridge_pkg

// File: hdl/cdc_fifo.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module cdc_fifo #(
    parameter type payload_t = logic
) (
    input  logic     wclk_i,
    input  logic     wrst_ni,
    input  logic     wr_en_i,
    input  payload_t wr_data_i,
    input  logic     rclk_i,
    input  logic     rrst_ni,
    input  logic     rd_en_i,
    output payload_t rd_data_o,
    output logic     empty_o
);

    localparam int unsigned AW    = `BRIDGE_FIFO_AW;
    localparam int unsigned PW    = AW + 1;
    localparam int unsigned DEPTH = 1 << AW;
    localparam int unsigned SYNC  = `BRIDGE_SYNC_STAGES;

    // Gray pointers differ in the two top bits when the FIFO is full
    localparam logic [AW:0] FULL_XOR = PW'(3) << (AW - 1);

    payload_t mem [DEPTH];

    logic [AW:0] wbin_q;
    logic [AW:0] wgray_q;
    logic [AW:0] wbin_next;
    logic [AW:0] wgray_next;
    logic        full_q;
    logic        wr_ok;

    logic [AW:0] rbin_q;
    logic [AW:0] rgray_q;
    logic [AW:0] rbin_next;
    logic [AW:0] rgray_next;
    logic        empty_q;
    logic        rd_ok;

    logic [AW:0] rgray_sync_q [SYNC];
    logic [AW:0] wgray_sync_q [SYNC];

    //////////////////////////////////////////////////////////////////////
    // Write domain
    //////////////////////////////////////////////////////////////////////

    // Writes while full are dropped
    assign wr_ok      = wr_en_i && !full_q;
    assign wbin_next  = wbin_q + PW'(wr_ok);
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;

    always_ff @(posedge wclk_i or negedge wrst_ni) begin
        if (wrst_ni == 1'b0) begin
            wbin_q  <= '0;
            wgray_q <= '0;
            full_q  <= 1'b0;
        end else begin
            wbin_q  <= wbin_next;
            wgray_q <= wgray_next;
            full_q  <= ((wgray_next ^ rgray_sync_q[SYNC-1]) == FULL_XOR);
        end
    end

    always_ff @(posedge wclk_i) begin
        if (wr_ok) begin
            mem[wbin_q[AW-1:0]] <= wr_data_i;
        end
    end

    // Read pointer into the write domain
    always_ff @(posedge wclk_i or negedge wrst_ni) begin
        if (wrst_ni == 1'b0) begin
            rgray_sync_q <= '{default: '0};
        end else begin
            rgray_sync_q[0] <= rgray_q;
            for (int i = 1; i < SYNC; i++) begin
                rgray_sync_q[i] <= rgray_sync_q[i-1];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read domain
    //////////////////////////////////////////////////////////////////////

    assign rd_ok      = rd_en_i && !empty_q;
    assign rbin_next  = rbin_q + PW'(rd_ok);
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    always_ff @(posedge rclk_i or negedge rrst_ni) begin
        if (rrst_ni == 1'b0) begin
            rbin_q  <= '0;
            rgray_q <= '0;
            empty_q <= 1'b1;
        end else begin
            rbin_q  <= rbin_next;
            rgray_q <= rgray_next;
            empty_q <= (rgray_next == wgray_sync_q[SYNC-1]);
        end
    end

    // Write pointer into the read domain
    always_ff @(posedge rclk_i or negedge rrst_ni) begin
        if (rrst_ni == 1'b0) begin
            wgray_sync_q <= '{default: '0};
        end else begin
            wgray_sync_q[0] <= wgray_q;
            for (int i = 1; i < SYNC; i++) begin
                wgray_sync_q[i] <= wgray_sync_q[i-1];
            end
        end
    end

    // Head entry is shown without a read strobe
    assign rd_data_o = mem[rbin_q[AW-1:0]];
    assign empty_o   = empty_q;

endmodule : cdc_fifo

// File: hdl/ahb_slave_port.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module ahb_slave_port (
    input  logic                        hclk_i,
    input  logic                        hrst_ni,
    input  logic                        hsel_i,
    input  bridge_pkg::htrans_e         htrans_i,
    input  logic [`BRIDGE_ADDR_W-1:0]   haddr_i,
    input  logic                        hwrite_i,
    input  logic [`BRIDGE_DATA_W-1:0]   hwdata_i,
    input  logic [`BRIDGE_DATA_W/8-1:0] hwstrb_i,
    output logic                        hreadyout_o,
    output logic [`BRIDGE_DATA_W-1:0]   hrdata_o,
    output logic                        hresp_o,
    output logic                        req_wr_en_o,
    output bridge_pkg::apb_req_t        req_wr_data_o,
    input  logic                        rsp_empty_i,
    input  bridge_pkg::apb_rsp_t        rsp_rd_data_i,
    output logic                        rsp_rd_en_o
);

    import bridge_pkg::*;

    logic                      accept;
    logic                      pend_q;
    logic                      data_phase_q;
    logic [`BRIDGE_ADDR_W-1:0] addr_q;
    logic                      write_q;

    //////////////////////////////////////////////////////////////////////
    // Transfer tracker
    //////////////////////////////////////////////////////////////////////

    // Only active transfers start a request
    assign accept = hsel_i && hreadyout_o &&
                    (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ);

    always_ff @(posedge hclk_i or negedge hrst_ni) begin
        if (hrst_ni == 1'b0) begin
            pend_q       <= 1'b0;
            data_phase_q <= 1'b0;
        end else begin
            data_phase_q <= accept;
            if (accept) begin
                pend_q <= 1'b1;
            end else if (rsp_rd_en_o) begin
                pend_q <= 1'b0;
            end
        end
    end

    // Wait states last for the whole pending window
    assign hreadyout_o = ~pend_q;

    // Address phase held until the data phase push
    always_ff @(posedge hclk_i) begin
        if (accept) begin
            addr_q  <= haddr_i;
            write_q <= hwrite_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request push
    //////////////////////////////////////////////////////////////////////

    assign req_wr_en_o = data_phase_q;

    // Reads carry no data and no strobes
    always_comb begin
        req_wr_data_o.addr  = addr_q;
        req_wr_data_o.write = write_q;
        req_wr_data_o.wdata = write_q ? hwdata_i : '0;
        req_wr_data_o.strb  = write_q ? hwstrb_i : '0;
    end

    //////////////////////////////////////////////////////////////////////
    // Response pop
    //////////////////////////////////////////////////////////////////////

    assign rsp_rd_en_o = pend_q && !rsp_empty_i;

    always_ff @(posedge hclk_i or negedge hrst_ni) begin
        if (hrst_ni == 1'b0) begin
            hresp_o  <= 1'b0;
            hrdata_o <= '0;
        end else begin
            // Error flag lasts one cycle
            hresp_o <= rsp_rd_en_o && rsp_rd_data_i.slverr;
            if (rsp_rd_en_o && !write_q) begin
                hrdata_o <= rsp_rd_data_i.rdata;
            end
        end
    end

endmodule : ahb_slave_port

// File: hdl/apb_master_port.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module apb_master_port (
    input  logic                        pclk_i,
    input  logic                        prst_ni,
    input  logic                        req_empty_i,
    input  bridge_pkg::apb_req_t        req_rd_data_i,
    output logic                        req_rd_en_o,
    output logic                        rsp_wr_en_o,
    output bridge_pkg::apb_rsp_t        rsp_wr_data_o,
    output logic [`BRIDGE_ADDR_W-1:0]   paddr_o,
    output logic                        pwrite_o,
    output logic [`BRIDGE_DATA_W-1:0]   pwdata_o,
    output logic [`BRIDGE_DATA_W/8-1:0] pstrb_o,
    output logic                        psel_o,
    output logic                        penable_o,
    input  logic                        pready_i,
    input  logic [`BRIDGE_DATA_W-1:0]   prdata_i,
    input  logic                        pslverr_i
);

    import bridge_pkg::*;

    apb_state_e state_q;
    apb_state_e state_d;
    logic       done;

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            APB_IDLE: begin
                if (!req_empty_i) begin
                    state_d = APB_SETUP;
                end
            end
            APB_SETUP: begin
                state_d = APB_ACCESS;
            end
            APB_ACCESS: begin
                // Slave stretches the access with pready low
                if (pready_i) begin
                    state_d = APB_IDLE;
                end
            end
            default: begin
                state_d = APB_IDLE;
            end
        endcase
    end

    always_ff @(posedge pclk_i or negedge prst_ni) begin
        if (prst_ni == 1'b0) begin
            state_q <= APB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // APB outputs
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge pclk_i or negedge prst_ni) begin
        if (prst_ni == 1'b0) begin
            psel_o    <= 1'b0;
            penable_o <= 1'b0;
            paddr_o   <= '0;
            pwrite_o  <= 1'b0;
            pwdata_o  <= '0;
            pstrb_o   <= '0;
        end else begin
            psel_o    <= (state_d != APB_IDLE);
            penable_o <= (state_d == APB_ACCESS);
            case (state_d)
                APB_IDLE: begin
                    paddr_o  <= '0;
                    pwrite_o <= 1'b0;
                    pwdata_o <= '0;
                    pstrb_o  <= '0;
                end
                APB_SETUP: begin
                    paddr_o  <= req_rd_data_i.addr;
                    pwrite_o <= req_rd_data_i.write;
                    pwdata_o <= req_rd_data_i.wdata;
                    pstrb_o  <= req_rd_data_i.strb;
                end
                // Held through the access phase
                default: begin
                end
            endcase
        end
    end

    // Pop the request and push the response on the same edge
    assign done        = (state_q == APB_ACCESS) && pready_i;
    assign req_rd_en_o = done;
    assign rsp_wr_en_o = done;

    always_comb begin
        rsp_wr_data_o.rdata  = pwrite_o ? '0 : prdata_i;
        rsp_wr_data_o.slverr = pslverr_i;
    end

endmodule : apb_master_port

// File: hdl/bridge_ahb_apb.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module bridge_ahb_apb (
    input  logic                        hclk_i,
    input  logic                        hrst_ni,
    input  logic                        hsel_i,
    input  bridge_pkg::htrans_e         htrans_i,
    input  logic [`BRIDGE_ADDR_W-1:0]   haddr_i,
    input  logic                        hwrite_i,
    input  logic [`BRIDGE_DATA_W-1:0]   hwdata_i,
    input  logic [`BRIDGE_DATA_W/8-1:0] hwstrb_i,
    output logic                        hreadyout_o,
    output logic [`BRIDGE_DATA_W-1:0]   hrdata_o,
    output logic                        hresp_o,

    input  logic                        pclk_i,
    input  logic                        prst_ni,
    output logic [`BRIDGE_ADDR_W-1:0]   paddr_o,
    output logic                        pwrite_o,
    output logic [`BRIDGE_DATA_W-1:0]   pwdata_o,
    output logic [`BRIDGE_DATA_W/8-1:0] pstrb_o,
    output logic                        psel_o,
    output logic                        penable_o,
    input  logic                        pready_i,
    input  logic [`BRIDGE_DATA_W-1:0]   prdata_i,
    input  logic                        pslverr_i
);

    import bridge_pkg::*;

    // Request path, hclk to pclk
    logic     req_wr_en;
    apb_req_t req_wr_data;
    logic     req_rd_en;
    apb_req_t req_rd_data;
    logic     req_empty;

    // Response path, pclk to hclk
    logic     rsp_wr_en;
    apb_rsp_t rsp_wr_data;
    logic     rsp_rd_en;
    apb_rsp_t rsp_rd_data;
    logic     rsp_empty;

    ahb_slave_port u_ahb (
        .*,
        .req_wr_en_o   (req_wr_en),
        .req_wr_data_o (req_wr_data),
        .rsp_empty_i   (rsp_empty),
        .rsp_rd_data_i (rsp_rd_data),
        .rsp_rd_en_o   (rsp_rd_en)
    );

    cdc_fifo #(.payload_t(apb_req_t)) u_req_fifo (
        .wclk_i    (hclk_i),
        .wrst_ni   (hrst_ni),
        .wr_en_i   (req_wr_en),
        .wr_data_i (req_wr_data),
        .rclk_i    (pclk_i),
        .rrst_ni   (prst_ni),
        .rd_en_i   (req_rd_en),
        .rd_data_o (req_rd_data),
        .empty_o   (req_empty)
    );

    apb_master_port u_apb (
        .*,
        .req_empty_i   (req_empty),
        .req_rd_data_i (req_rd_data),
        .req_rd_en_o   (req_rd_en),
        .rsp_wr_en_o   (rsp_wr_en),
        .rsp_wr_data_o (rsp_wr_data)
    );

    cdc_fifo #(.payload_t(apb_rsp_t)) u_rsp_fifo (
        .wclk_i    (pclk_i),
        .wrst_ni   (prst_ni),
        .wr_en_i   (rsp_wr_en),
        .wr_data_i (rsp_wr_data),
        .rclk_i    (hclk_i),
        .rrst_ni   (hrst_ni),
        .rd_en_i   (rsp_rd_en),
        .rd_data_o (rsp_rd_data),
        .empty_o   (rsp_empty)
    );

endmodule : bridge_ahb_apb

// File: test/bridge_props.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module bridge_props (
    input logic                        pclk_i,
    input logic                        prst_ni,
    input logic                        psel_o,
    input logic                        penable_o,
    input logic                        pready_i,
    input logic [`BRIDGE_ADDR_W-1:0]   paddr_o,
    input logic                        pwrite_o,
    input logic [`BRIDGE_DATA_W-1:0]   pwdata_o,
    input logic [`BRIDGE_DATA_W/8-1:0] pstrb_o
);

    // Count of failed properties, watched by the testbench
    int fail_count = 0;

    //////////////////////////////////////////////////////////////////////
    // APB sequence
    //////////////////////////////////////////////////////////////////////

    // Setup phase lasts exactly one cycle
    setup_to_access: assert property (@(posedge pclk_i) disable iff (!prst_ni)
        (psel_o && !penable_o) |=> penable_o)
        else begin fail_count++; $error("penable_o did not follow setup phase"); end

    access_end: assert property (@(posedge pclk_i) disable iff (!prst_ni)
        $fell(penable_o) |-> $past(pready_i))
        else begin fail_count++; $error("penable_o fell without pready_i"); end

    enable_needs_sel: assert property (@(posedge pclk_i) disable iff (!prst_ni)
        penable_o |-> psel_o)
        else begin fail_count++; $error("penable_o high without psel_o"); end

    // Address, direction and data held for the whole transfer
    stable_ctrl: assert property (@(posedge pclk_i) disable iff (!prst_ni)
        (psel_o && $past(psel_o)) |-> ($stable(paddr_o) && $stable(pwrite_o) &&
                                       $stable(pwdata_o) && $stable(pstrb_o)))
        else begin fail_count++; $error("APB outputs changed during transfer"); end

endmodule : bridge_props

bind bridge_ahb_apb bridge_props u_props (.*);

// File: test/tb_bridge.sv
`timescale 1ns/1ps
`include "bridge_config.svh"

module tb_bridge;

    import bridge_pkg::*;

    localparam int AW      = `BRIDGE_ADDR_W;
    localparam int DW      = `BRIDGE_DATA_W;
    localparam int SW      = `BRIDGE_DATA_W / 8;
    localparam int N_XFERS = 60;

    logic          hclk_i, hrst_ni, hsel_i, hwrite_i;
    htrans_e       htrans_i;
    logic [AW-1:0] haddr_i;
    logic [DW-1:0] hwdata_i;
    logic [SW-1:0] hwstrb_i;
    logic          hreadyout_o, hresp_o;
    logic [DW-1:0] hrdata_o;
    logic          pclk_i, prst_ni, pwrite_o, psel_o, penable_o;
    logic          pready_i, pslverr_i;
    logic [AW-1:0] paddr_o;
    logic [DW-1:0] pwdata_o, prdata_i;
    logic [SW-1:0] pstrb_o;

    int            seed = 21;
    logic [DW-1:0] ref_mem [16];
    logic [DW-1:0] slave_mem [16];
    logic          err_q [$];
    logic          write_q [$];
    logic [DW-1:0] rdata_q [$];
    logic [AW-1:0] apb_addr_q [$];
    logic          apb_write_q [$];
    logic [DW-1:0] apb_wdata_q [$];
    logic [SW-1:0] apb_strb_q [$];
    int            acc_cnt = 0;
    int            apb_cnt = 0;
    int            wait_cnt;
    logic          pending = 1'b0;

    bridge_ahb_apb DUT (.*);

    initial begin
        pclk_i = 1'b0;
        forever #10 pclk_i = ~pclk_i;
    end

    initial begin
        hclk_i = 1'b0;
        forever #7 hclk_i = ~hclk_i;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_w,
                                                  input logic [DW-1:0] new_w,
                                                  input logic [SW-1:0] strb);
        logic [DW-1:0] res;
        res = old_w;
        for (int b = 0; b < SW; b++) begin
            if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // AHB stimulus
    //////////////////////////////////////////////////////////////////////

    // Data phase and idle gap controls, active ones only while the bridge stalls
    task automatic drive_noise(input logic allow_active);
        case ($random(seed) & 3)
            0: begin
                hsel_i   <= 1'b0;
                htrans_i <= HTRANS_NONSEQ;
            end
            1: begin
                hsel_i   <= 1'b1;
                htrans_i <= HTRANS_BUSY;
            end
            2: begin
                hsel_i   <= 1'b1;
                htrans_i <= allow_active ? HTRANS_NONSEQ : HTRANS_IDLE;
            end
            default: begin
                hsel_i   <= 1'b1;
                htrans_i <= HTRANS_IDLE;
            end
        endcase
    endtask

    task automatic run_transfer();
        logic [3:0]    idx;
        logic          err;
        logic          wr;
        logic [DW-1:0] data;
        logic [SW-1:0] strb;
        logic [AW-1:0] addr;
        idx  = 4'($random(seed));
        err  = (($random(seed) & 3) == 0);
        wr   = 1'($random(seed));
        data = DW'($random(seed));
        strb = SW'($random(seed));
        addr = '0;
        addr[5:2] = idx;
        addr[8] = err;
        err_q.push_back(err);
        write_q.push_back(wr);
        rdata_q.push_back(ref_mem[idx]);
        apb_addr_q.push_back(addr);
        apb_write_q.push_back(wr);
        apb_wdata_q.push_back(data);
        apb_strb_q.push_back(strb);
        if (wr && !err) ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
        @(posedge hclk_i);
        hsel_i   <= 1'b1;
        htrans_i <= (($random(seed) & 1) != 0) ? HTRANS_SEQ : HTRANS_NONSEQ;
        haddr_i  <= addr;
        hwrite_i <= wr;
        hwstrb_i <= strb;
        @(posedge hclk_i);
        hwdata_i <= data;
        drive_noise(1'b1);
        // Active requests are withdrawn once the APB side has finished
        do begin
            @(posedge hclk_i);
            drive_noise(apb_cnt < acc_cnt);
        end while (!hreadyout_o);
    endtask

    //////////////////////////////////////////////////////////////////////
    // APB slave model
    //////////////////////////////////////////////////////////////////////

    always @(posedge pclk_i or negedge prst_ni) begin
        if (!prst_ni) begin
            pready_i  <= 1'b0;
            pslverr_i <= 1'b0;
            prdata_i  <= '0;
            wait_cnt  <= 0;
        end else if (psel_o && !penable_o) begin
            wait_cnt  <= $random(seed) & 3;
            pready_i  <= 1'b0;
            prdata_i  <= slave_mem[paddr_o[5:2]];
        end else if (psel_o && penable_o && pready_i) begin
            pready_i  <= 1'b0;
            pslverr_i <= 1'b0;
            if (pwrite_o && !paddr_o[8]) begin
                slave_mem[paddr_o[5:2]] <= merge_bytes(slave_mem[paddr_o[5:2]],
                                                       pwdata_o, pstrb_o);
            end
        end else if (psel_o && penable_o) begin
            // Wait states count down in the access phase
            if (wait_cnt == 0) begin
                pready_i  <= 1'b1;
                pslverr_i <= paddr_o[8];
            end
            wait_cnt <= wait_cnt - 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    always @(posedge hclk_i) begin
        if (hrst_ni) begin
            if (pending && hreadyout_o) begin
                assert (apb_cnt >= acc_cnt)
                    else report_fail("Response returned before the APB transfer ended");
                assert (hresp_o == err_q[0])
                    else report_fail($sformatf("[FAIL] hresp_o got %h expected %h",
                                               hresp_o, err_q[0]));
                if (!write_q[0]) begin
                    assert (hrdata_o == rdata_q[0])
                        else report_fail($sformatf("[FAIL] hrdata_o got %h expected %h",
                                                   hrdata_o, rdata_q[0]));
                end
                void'(err_q.pop_front());
                void'(write_q.pop_front());
                void'(rdata_q.pop_front());
                pending = 1'b0;
            end else begin
                assert (!hresp_o)
                    else report_fail($sformatf("[FAIL] hresp_o got %h expected 0", hresp_o));
            end
            if (hsel_i && hreadyout_o &&
                (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ)) begin
                pending = 1'b1;
                acc_cnt++;
            end
        end
    end

    always @(posedge pclk_i) begin
        if (prst_ni && psel_o && penable_o && pready_i) begin
            assert (apb_addr_q.size() > 0)
                else report_fail("APB transfer without an accepted AHB transfer");
            assert (paddr_o == apb_addr_q[0])
                else report_fail($sformatf("[FAIL] paddr_o got %h expected %h",
                                           paddr_o, apb_addr_q[0]));
            assert (pwrite_o == apb_write_q[0])
                else report_fail($sformatf("[FAIL] pwrite_o got %h expected %h",
                                           pwrite_o, apb_write_q[0]));
            if (pwrite_o) begin
                assert (pwdata_o == apb_wdata_q[0])
                    else report_fail($sformatf("[FAIL] pwdata_o got %h expected %h",
                                               pwdata_o, apb_wdata_q[0]));
                assert (pstrb_o == apb_strb_q[0])
                    else report_fail($sformatf("[FAIL] pstrb_o got %h expected %h",
                                               pstrb_o, apb_strb_q[0]));
            end
            void'(apb_addr_q.pop_front());
            void'(apb_write_q.pop_front());
            void'(apb_wdata_q.pop_front());
            void'(apb_strb_q.pop_front());
            apb_cnt++;
        end
        if (DUT.u_props.fail_count != 0) report_fail("APB protocol property failed");
    end

    resp_with_ready: assert property (@(posedge hclk_i) disable iff (!hrst_ni)
        hresp_o |-> hreadyout_o)
        else report_fail($sformatf("[FAIL] hreadyout_o got %h expected 1", hreadyout_o));

    idle_zero: assert property (@(posedge pclk_i) disable iff (!prst_ni)
        !psel_o |-> (paddr_o == '0 && pstrb_o == '0))
        else report_fail($sformatf("[FAIL] paddr_o got %h expected 0", paddr_o));

    initial begin
        #(N_XFERS * 40 * 20);
        $display("Timeout, the bridge hung and transfers did not complete");
        report_fail("Run stopped by watchdog");
    end

    initial begin
        hrst_ni   = 1'b0;
        prst_ni   = 1'b0;
        hsel_i    = 1'b0;
        htrans_i  = HTRANS_IDLE;
        haddr_i   = '0;
        hwrite_i  = 1'b0;
        hwdata_i  = '0;
        hwstrb_i  = '0;
        pready_i  = 1'b0;
        pslverr_i = 1'b0;
        prdata_i  = '0;
        for (int i = 0; i < 16; i++) begin
            ref_mem[i]   = 32'hA5C3_0000 ^ (i * 32'h0101_0107);
            slave_mem[i] = ref_mem[i];
        end
        repeat (4) @(posedge pclk_i);
        prst_ni <= 1'b1;
        @(posedge hclk_i);
        hrst_ni <= 1'b1;
        @(posedge hclk_i);
        assert (hreadyout_o && !hresp_o && !psel_o && !penable_o)
            else report_fail($sformatf("[FAIL] reset hreadyout_o %h hresp_o %h psel_o %h",
                                       hreadyout_o, hresp_o, psel_o));
        for (int n = 0; n < N_XFERS; n++) begin
            run_transfer();
        end
        repeat (20) @(posedge pclk_i);
        if (apb_cnt != acc_cnt || apb_addr_q.size() != 0 || pending) begin
            $display("[FAIL] apb_cnt %h does not match acc_cnt %h", apb_cnt, acc_cnt);
            $display("Test FAILED");
            $fatal(1);
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule : tb_bridge

// File: project.f
+incdir+hdl
hdl/bridge_pkg.sv
hdl/cdc_fifo.sv
hdl/ahb_slave_port.sv
hdl/apb_master_port.sv
hdl/bridge_ahb_apb.sv
test/bridge_props.sv
test/tb_bridge.sv

// File: Makefile
# Verilator build and run for the AHB to APB bridge

TOP = tb_bridge
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) \
		--Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
